// ==== hw/decode_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_fifo #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 4          // power of two
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         push_i,
	input  wire entry_t data_i,
	input  wire         pop_i,
	output entry_t      data_o,
	output logic        not_empty_o,
	output logic        credit_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full        = (count == CNT_W'(DEPTH));
	assign not_empty_o = (count != '0);
	assign data_o      = mem[rd_ptr];   // show-ahead head

	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push_i)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop_i)
				rd_ptr <= ptr_inc(rd_ptr);
			count    <= count + CNT_W'(push_i) - CNT_W'(pop_i);
			credit_o <= pop_i;      // one freed slot back to fetch
		end
	end

	// upstream credits keep the classifier from overrunning the buffer
	assert property (@(posedge clk) disable iff (rst) push_i |-> !full)
		else $error("decode_fifo: push while full");
	assert property (@(posedge clk) disable iff (rst) pop_i |-> not_empty_o)
		else $error("decode_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== hw/inst_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_macros.svh"

module inst_classifier import rv_decode_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire fetch_pkt_t pkt_i,
	input  wire             valid_i,
	output id_entry_t       entry_o,
	output logic            entry_valid_o
);

	logic [`ILEN-1:0] inst;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;     // rv64 immediate shifts
	logic op_lui, op_auipc, op_jal, op_jalr, op_branch;
	logic op_load, op_store, op_imm, op_imm32, op_reg, op_reg32;
	logic legal;
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	alu_op_e alu_fn;
	id_entry_t dec;

	assign inst   = pkt_i.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign funct6 = inst[31:26];

	assign op_lui    = (opcode == `OPC_LUI);
	assign op_auipc  = (opcode == `OPC_AUIPC);
	assign op_jal    = (opcode == `OPC_JAL);
	assign op_jalr   = (opcode == `OPC_JALR);
	assign op_branch = (opcode == `OPC_BRANCH);
	assign op_load   = (opcode == `OPC_LOAD);
	assign op_store  = (opcode == `OPC_STORE);
	assign op_imm    = (opcode == `OPC_IMM);
	assign op_imm32  = (opcode == `OPC_IMM32);
	assign op_reg    = (opcode == `OPC_REG);
	assign op_reg32  = (opcode == `OPC_REG32);

	// b and j immediates are scrambled in the encoding
	assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			`OPC_LUI, `OPC_AUIPC, `OPC_JAL: legal = 1'b1;
			`OPC_JALR:   legal = (funct3 == 3'd0);
			`OPC_BRANCH: legal = (funct3[2:1] != 2'b01);   // 2 and 3 unused
			`OPC_LOAD:   legal = (funct3 != 3'd7);
			`OPC_STORE:  legal = !funct3[2];
			`OPC_IMM: begin
				case (funct3)
					3'd1:    legal = (funct6 == 6'h00);
					3'd5:    legal = (funct6 == 6'h00) || (funct6 == 6'h10);
					default: legal = 1'b1;
				endcase
			end
			`OPC_IMM32: begin
				case (funct3)
					3'd0:    legal = 1'b1;
					3'd1:    legal = (funct7 == 7'h00);
					3'd5:    legal = (funct7 == 7'h00) || (funct7 == 7'h20);
					default: legal = 1'b0;
				endcase
			end
			`OPC_REG: legal = (funct7 == 7'h00) ||
				((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
			`OPC_REG32: begin
				case (funct3)
					3'd0, 3'd5: legal = (funct7 == 7'h00) || (funct7 == 7'h20);
					3'd1:       legal = (funct7 == 7'h00);
					default:    legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	// shared by immediate and register alu ops
	always_comb begin
		case (funct3)
			3'd0:    alu_fn = ((op_reg || op_reg32) && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'd1:    alu_fn = ALU_SLL;
			3'd2:    alu_fn = ALU_SLT;
			3'd3:    alu_fn = ALU_SLT;   // sltu, unsigned flag set below
			3'd4:    alu_fn = ALU_XOR;
			3'd5:    alu_fn = inst[30] ? ALU_SRA : ALU_SRL;
			3'd6:    alu_fn = ALU_OR;
			default: alu_fn = ALU_AND;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.pkt = pkt_i;
		dec.rd = inst[11:7];
		dec.size = `SIZE_D;
		dec.illegal = !legal;
		if (legal) begin
			dec.gpr_write = !(op_branch || op_store);
			dec.word_op = op_imm32 || op_reg32;
			dec.load = op_load;
			dec.store = op_store;
			dec.jump = op_jal || op_jalr;
			if (op_imm32 || op_reg32)
				dec.size = `SIZE_W;
			if (op_load || op_store) begin
				case (funct3[1:0])
					2'd0:    dec.size = `SIZE_B;
					2'd1:    dec.size = `SIZE_H;
					2'd2:    dec.size = `SIZE_W;
					default: dec.size = `SIZE_D;
				endcase
			end
			dec.is_unsigned = ((op_imm || op_reg) && (funct3 == 3'd3)) ||
				(op_branch && (funct3[2:1] == 2'b11)) || (op_load && funct3[2]);
			dec.shamt_imm_sel = (op_imm || op_imm32) && (funct3[1:0] == 2'b01);
			dec.shamt_imm = op_imm32 ? {1'b0, inst[24:20]} : inst[25:20];

			if (op_lui || op_auipc)
				dec.data_imm = imm_u;
			else if (op_imm || op_imm32)
				dec.data_imm = imm_i;
			if (op_branch)
				dec.addr_imm = imm_b;
			else if (op_jal)
				dec.addr_imm = imm_j;
			else if (op_store)
				dec.addr_imm = imm_s;
			else if (op_jalr || op_load)
				dec.addr_imm = imm_i;

			if (op_lui)
				dec.ds1_src = SRC_IMM;
			else if (op_auipc || op_jal || op_jalr)
				dec.ds1_src = SRC_PC;
			else if (!(op_load || op_store))
				dec.ds1_src = SRC_RS1;
			if (op_reg || op_reg32 || op_branch || op_store)
				dec.ds2_src = SRC_RS2;
			else if (op_imm || op_imm32 || op_auipc)
				dec.ds2_src = SRC_IMM;
			else if (op_jal || op_jalr)
				dec.ds2_src = SRC_LINK;
			dec.as1_src = (op_branch || op_jal) ? SRC_PC : SRC_RS1;

			if (op_auipc || op_jal || op_jalr)
				dec.alu_op = ALU_ADD;   // pc + imm or pc + 4
			else if (op_branch)
				dec.alu_op = ALU_COMPARE;
			else if (op_imm || op_imm32 || op_reg || op_reg32)
				dec.alu_op = alu_fn;
			if (op_branch) begin
				case (funct3)
					3'd0:       dec.br_cond = BR_EQ;
					3'd1:       dec.br_cond = BR_NE;
					3'd4, 3'd6: dec.br_cond = BR_LT;
					default:    dec.br_cond = BR_GE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			entry_valid_o <= 1'b0;
		else
			entry_valid_o <= valid_i;
	end

	always_ff @(posedge clk) begin
		if (valid_i)
			entry_o <= dec;
	end

	// an illegal entry must never reach writeback
	assert property (@(posedge clk) disable iff (rst)
		entry_valid_o |-> !(entry_o.illegal && entry_o.gpr_write))
		else $error("inst_classifier: illegal entry with gpr write");

endmodule

`default_nettype wire

// ==== hw/operand_issue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_macros.svh"

module operand_issue import rv_decode_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire id_entry_t entry_i,
	input  wire            avail_i,
	output logic           pop_o,
	input  wire            credit_i,
	output ex_uop_t        uop_o,
	output logic           uop_valid_o
);

	// one spare code so an extra credit shows up instead of wrapping
	localparam int CNT_W = $clog2(`EX_CREDITS + 2);

	logic [CNT_W-1:0] credit_cnt;
	ex_uop_t uop_d;

	function automatic logic [`XLEN-1:0] src_value(input opnd_src_e src, input id_entry_t e);
		logic [`XLEN-1:0] v;
		case (src)
			SRC_RS1:  v = e.pkt.rs1;
			SRC_RS2:  v = e.pkt.rs2;
			SRC_PC:   v = e.pkt.pc;
			SRC_IMM:  v = e.data_imm;
			SRC_LINK: v = `XLEN'(`LINK_OFFSET);
			default:  v = '0;
		endcase
		return v;
	endfunction

	assign pop_o = avail_i && (credit_cnt != '0);

	always_comb begin
		uop_d = '0;
		uop_d.pc          = entry_i.pkt.pc;
		uop_d.alu_op      = entry_i.alu_op;
		uop_d.br_cond     = entry_i.br_cond;
		uop_d.jump        = entry_i.jump;
		uop_d.size        = entry_i.size;
		uop_d.is_unsigned = entry_i.is_unsigned;
		uop_d.word_op     = entry_i.word_op;
		uop_d.load        = entry_i.load;
		uop_d.store       = entry_i.store;
		uop_d.gpr_write   = entry_i.gpr_write;
		uop_d.rd          = entry_i.rd;
		uop_d.illegal     = entry_i.illegal;
		if (entry_i.illegal) begin
			uop_d.size       = `SIZE_W;
			uop_d.trap_value = `XLEN'(entry_i.pkt.inst);   // operands stay zero
		end else begin
			uop_d.ds1 = src_value(entry_i.ds1_src, entry_i);
			uop_d.ds2 = src_value(entry_i.ds2_src, entry_i);
			uop_d.as1 = src_value(entry_i.as1_src, entry_i);
			uop_d.as2 = entry_i.addr_imm;
			uop_d.shamt = entry_i.shamt_imm_sel ? entry_i.shamt_imm :
				entry_i.pkt.rs2[`SHAMT_W-1:0];
		end
	end

	// execute credits, spent on issue and returned by credit_i
	always_ff @(posedge clk) begin
		if (rst)
			credit_cnt <= CNT_W'(`EX_CREDITS);
		else
			credit_cnt <= credit_cnt - CNT_W'(pop_o) + CNT_W'(credit_i);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			uop_valid_o <= 1'b0;
			uop_o       <= '0;
		end else begin
			uop_valid_o <= pop_o;
			if (pop_o)
				uop_o <= uop_d;
		end
	end

	// execute must not return more credits than it was granted
	assert property (@(posedge clk) disable iff (rst) credit_cnt <= CNT_W'(`EX_CREDITS))
		else $error("operand_issue: credit count above grant");
	assert property (@(posedge clk) disable iff (rst) uop_valid_o |-> $past(credit_cnt) != '0)
		else $error("operand_issue: issued without credit");

endmodule

`default_nettype wire

// ==== hw/rv_decode_pkg.sv ====
`default_nettype none
`include "rv_decode_macros.svh"

package rv_decode_pkg;

	// one fetched instruction with its register reads
	typedef struct packed {
		logic [`ILEN-1:0] inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1;
		logic [`XLEN-1:0] rs2;
	} fetch_pkt_t;

	typedef enum logic [3:0] {
		ALU_PASS    = 4'd0,     // ds1 straight through
		ALU_ADD     = 4'd1,
		ALU_SUB     = 4'd2,
		ALU_AND     = 4'd3,
		ALU_OR      = 4'd4,
		ALU_XOR     = 4'd5,
		ALU_SLT     = 4'd6,
		ALU_SLL     = 4'd7,
		ALU_SRL     = 4'd8,
		ALU_SRA     = 4'd9,
		ALU_COMPARE = 4'd10     // branch compare, see br_cond
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4
	} br_cond_e;

	typedef enum logic [2:0] {
		SRC_ZERO = 3'd0,
		SRC_RS1  = 3'd1,
		SRC_RS2  = 3'd2,
		SRC_PC   = 3'd3,
		SRC_IMM  = 3'd4,    // the selected data immediate
		SRC_LINK = 3'd5
	} opnd_src_e;

	typedef struct packed {
		fetch_pkt_t          pkt;
		alu_op_e             alu_op;
		br_cond_e            br_cond;
		logic                jump;
		opnd_src_e           ds1_src;
		opnd_src_e           ds2_src;
		opnd_src_e           as1_src;
		logic [`XLEN-1:0]    data_imm;   // I or U
		logic [`XLEN-1:0]    addr_imm;   // I, S, B or J
		logic                shamt_imm_sel;
		logic [`SHAMT_W-1:0] shamt_imm;
		logic [3:0]          size;
		logic                is_unsigned;
		logic                word_op;
		logic                load;
		logic                store;
		logic                gpr_write;
		logic [`REG_IDX_W-1:0] rd;
		logic                illegal;
	} id_entry_t;

	typedef struct packed {
		logic [`XLEN-1:0]    pc;
		alu_op_e             alu_op;
		br_cond_e            br_cond;
		logic                jump;
		logic [`XLEN-1:0]    ds1;
		logic [`XLEN-1:0]    ds2;
		logic [`XLEN-1:0]    as1;
		logic [`XLEN-1:0]    as2;
		logic [`SHAMT_W-1:0] shamt;
		logic [3:0]          size;
		logic                is_unsigned;
		logic                word_op;
		logic                load;
		logic                store;
		logic                gpr_write;
		logic [`REG_IDX_W-1:0] rd;
		logic                illegal;
		logic [`XLEN-1:0]    trap_value;
	} ex_uop_t;

endpackage

`default_nettype wire

// ==== hw/rv_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_macros.svh"

module rv_decode_top import rv_decode_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire fetch_pkt_t fetch_i,
	input  wire             fetch_valid_i,
	output wire             in_credit_o,
	output ex_uop_t         uop_o,
	output wire             uop_valid_o,
	input  wire             ex_credit_i
);

	id_entry_t cls_entry;   // classifier register to fifo
	logic      cls_valid;
	id_entry_t head_entry;
	logic      head_avail;
	logic      issue_pop;

	inst_classifier inst_classifier_i (
		.clk           (clk),
		.rst           (rst),
		.pkt_i         (fetch_i),
		.valid_i       (fetch_valid_i),
		.entry_o       (cls_entry),
		.entry_valid_o (cls_valid)
	);

	decode_fifo #(
		.entry_t (id_entry_t),
		.DEPTH   (`ID_FIFO_DEPTH)
	) decode_fifo_i (
		.clk         (clk),
		.rst         (rst),
		.push_i      (cls_valid),
		.data_i      (cls_entry),
		.pop_i       (issue_pop),
		.data_o      (head_entry),
		.not_empty_o (head_avail),
		.credit_o    (in_credit_o)
	);

	operand_issue operand_issue_i (
		.clk         (clk),
		.rst         (rst),
		.entry_i     (head_entry),
		.avail_i     (head_avail),
		.pop_o       (issue_pop),
		.credit_i    (ex_credit_i),
		.uop_o       (uop_o),
		.uop_valid_o (uop_valid_o)
	);

endmodule

`default_nettype wire

// ==== include/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// datapath widths
`define XLEN        64
`define ILEN        32
`define REG_IDX_W   5
`define SHAMT_W     6   // rv64 shifts use six bits

// major opcodes, inst[6:0]
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_IMM     7'b0010011
`define OPC_IMM32   7'b0011011
`define OPC_REG     7'b0110011
`define OPC_REG32   7'b0111011

// one-hot access size
`define SIZE_B      4'b0001
`define SIZE_H      4'b0010
`define SIZE_W      4'b0100
`define SIZE_D      4'b1000

// flow control
`define ID_FIFO_DEPTH  4
`define EX_CREDITS     2    // granted by execute after reset

`define LINK_OFFSET    4    // return address is pc + 4

`endif

// ==== run_sim.sh ====
#!/bin/sh
# builds the decode-stage testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rv_decode \
	-f rv_decode.f \
	-o sim_rv_decode

# the simulator exits non-zero on $fatal, the output still decides
output=$(./obj_dir/sim_rv_decode 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== rv_decode.f ====
+incdir+include
hw/rv_decode_pkg.sv
hw/inst_classifier.sv
hw/decode_fifo.sv
hw/operand_issue.sv
hw/rv_decode_top.sv
verification/tb_rv_decode.sv

// ==== verification/rv_decode_trace.txt ====
// inst pc rs1 rs2, then expected ds1 ds2 as1 as2 alu_op br_cond size flags shamt rd trap_value
// flags msb first: jump unsigned word_op load store gpr_write illegal
123452b7 1000 100 23 12345000 0 100 0 0 0 8 02 23 05 0
fffff297 1004 101 23 1004 fffffffffffff000 101 0 1 0 8 02 23 05 0
7f030293 1008 102 23 102 7f0 102 0 1 0 8 02 23 05 0
fff30293 100c 103 23 103 ffffffffffffffff 103 0 1 0 8 02 23 05 0
00533293 1010 104 23 104 5 104 0 6 0 8 22 23 05 0
0ff34293 1014 105 23 105 ff 105 0 5 0 8 02 23 05 0
02131293 1018 106 23 106 21 106 0 7 0 8 02 21 05 0
43f35293 101c 107 23 107 43f 107 0 9 0 8 02 3f 05 0
ff03029b 1020 108 23 108 fffffffffffffff0 108 0 1 0 4 12 23 05 0
01f3529b 1024 109 23 109 1f 109 0 8 0 4 12 1f 05 0
007302b3 1028 10a 23 10a 23 10a 0 1 0 8 02 23 05 0
407302b3 102c 10b 23 10b 23 10b 0 2 0 8 02 23 05 0
007312b3 1030 10c 7e 10c 7e 10c 0 7 0 8 02 3e 05 0
007332b3 1034 10d 23 10d 23 10d 0 6 0 8 22 23 05 0
407352b3 1038 10e 45 10e 45 10e 0 9 0 8 02 05 05 0
407302bb 103c 10f 23 10f 23 10f 0 2 0 4 12 23 05 0
007312bb 1040 110 23 110 23 110 0 7 0 4 12 23 05 0
00730863 1044 111 23 111 23 1044 10 a 1 8 00 23 10 0
fe731ce3 1048 112 23 112 23 1048 fffffffffffffff8 a 2 8 00 23 19 0
02736063 104c 113 23 113 23 104c 20 a 3 8 20 23 00 0
00735263 1050 114 23 114 23 1050 4 a 4 8 00 23 04 0
001000ef 1054 115 23 1054 4 1054 800 1 0 8 42 23 01 0
010300e7 1058 116 23 1058 4 116 10 1 0 8 42 23 01 0
ffc30283 105c 117 23 0 0 117 fffffffffffffffc 0 0 1 0a 23 05 0
00235283 1060 118 23 0 0 118 2 0 0 2 2a 23 05 0
00836283 1064 119 23 0 0 119 8 0 0 4 2a 23 05 0
01033283 1068 11a 23 0 0 11a 10 0 0 8 0a 23 05 0
007302a3 106c 11b 23 0 23 11b 5 0 0 1 04 23 05 0
fe733023 1070 11c 23 0 23 11c ffffffffffffffe0 0 0 8 04 23 00 0
04732023 1074 11d 23 0 23 11d 40 0 0 4 04 23 00 0
1234567f 1078 11e 23 0 0 0 0 0 0 4 01 0 0c 1234567f
027302b3 107c 11f 23 0 0 0 0 0 0 4 01 0 05 27302b3

// ==== verification/tb_rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_macros.svh"

module tb_rv_decode import rv_decode_pkg::*; ();

	localparam int NCOL     = 15;   // hex words per trace line
	localparam int MAX_ROWS = 64;

	logic       clk;
	logic       rst;
	fetch_pkt_t fetch;
	logic       fetch_valid;
	logic       in_credit;
	ex_uop_t    uop;
	logic       uop_valid;
	logic       ex_credit;

	logic [63:0] trace_mem [NCOL*MAX_ROWS];
	int num_rows;
	int in_idx;
	int out_idx;
	int fetch_cred;         // fetch side view of free decode slots
	int ex_cred;            // execute credits as the dut sees them
	logic ex_credit_seen;   // pulse of the last cycle, counted by the dut at the next edge
	int owed;               // micro-ops not yet credited back
	int hold;
	int cycle_cnt;
	int cycle_limit;
	integer seed;

	rv_decode_top rv_decode_top_i (
		.clk           (clk),
		.rst           (rst),
		.fetch_i       (fetch),
		.fetch_valid_i (fetch_valid),
		.in_credit_o   (in_credit),
		.uop_o         (uop),
		.uop_valid_o   (uop_valid),
		.ex_credit_i   (ex_credit)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "run aborted");
	endtask

	task automatic check_field(input int row, input string field, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp) else begin
			$display("Fail trace line %0d %s: expected %h, actual %h", row + 1, field, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "micro-op mismatch");
		end
	endtask

	task automatic check_uop(input int row);
		int b;
		logic [6:0] flags;
		b = row * NCOL;
		flags = {uop.jump, uop.is_unsigned, uop.word_op, uop.load, uop.store,
			uop.gpr_write, uop.illegal};
		check_field(row, "pc", trace_mem[b+1], uop.pc);
		check_field(row, "ds1", trace_mem[b+4], uop.ds1);
		check_field(row, "ds2", trace_mem[b+5], uop.ds2);
		check_field(row, "as1", trace_mem[b+6], uop.as1);
		check_field(row, "as2", trace_mem[b+7], uop.as2);
		check_field(row, "alu_op", trace_mem[b+8], 64'(uop.alu_op));
		check_field(row, "br_cond", trace_mem[b+9], 64'(uop.br_cond));
		check_field(row, "size", trace_mem[b+10], 64'(uop.size));
		check_field(row, "flags", trace_mem[b+11], 64'(flags));
		check_field(row, "shamt", trace_mem[b+12], 64'(uop.shamt));
		check_field(row, "rd", trace_mem[b+13], 64'(uop.rd));
		check_field(row, "trap_value", trace_mem[b+14], uop.trap_value);
	endtask

	task automatic load_trace();
		int i;
		// upper half set marks words the file leaves unwritten
		for (i = 0; i < NCOL*MAX_ROWS; i++)
			trace_mem[i] = {32'hffff_ffff, 32'(i)};
		$readmemh("verification/rv_decode_trace.txt", trace_mem);
		num_rows = 0;
		while (num_rows < MAX_ROWS && trace_mem[num_rows*NCOL][63:32] == 32'h0)
			num_rows++;
	endtask

	// mostly short gaps, now and then a long execute stall
	function automatic int next_delay();
		int r;
		r = $random(seed) & 32'h3f;
		if (r < 6)
			return 20 + r;
		return r & 3;
	endfunction

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		fetch = '0;
		fetch_valid = 1'b0;
		ex_credit = 1'b0;
		ex_credit_seen = 1'b0;
		seed = 32'hf6074f91;
		in_idx = 0;
		out_idx = 0;
		fetch_cred = `ID_FIFO_DEPTH;
		ex_cred = `EX_CREDITS;
		owed = 0;
		hold = 0;
		cycle_cnt = 0;
		load_trace();
		cycle_limit = 40 * num_rows + 100;
		assert (num_rows > 0) else abort_run("trace file holds no instructions");

		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		repeat (4) @(posedge clk);   // idle window, outputs must stay quiet

		while (in_idx < num_rows) begin
			@(posedge clk);
			#1;
			if (fetch_cred > 0) begin
				fetch.inst  = trace_mem[in_idx*NCOL][31:0];
				fetch.pc    = trace_mem[in_idx*NCOL+1];
				fetch.rs1   = trace_mem[in_idx*NCOL+2];
				fetch.rs2   = trace_mem[in_idx*NCOL+3];
				fetch_valid = 1'b1;
				fetch_cred--;
				in_idx++;
			end else begin
				fetch_valid = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
		fetch = '0;

		while (out_idx < num_rows)
			@(posedge clk);
		repeat (10) @(posedge clk);   // any extra micro-op shows up here

		if (out_idx == num_rows && fetch_cred == `ID_FIFO_DEPTH) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("issued %0d of %0d micro-ops, %0d fetch credits back", out_idx,
				num_rows, fetch_cred);
			$display("=== FAIL ===");
			$fatal(1, "incomplete run");
		end
	end

	// output side sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (in_idx == 0) begin
				assert (!uop_valid && !in_credit && uop == '0)
					else abort_run("outputs active before the first instruction");
			end
			if (uop_valid) begin
				assert (out_idx < num_rows)
					else abort_run("micro-op issued beyond the end of the trace");
				assert (ex_cred > 0)
					else abort_run("micro-op issued without an execute credit");
				check_uop(out_idx);
				out_idx++;
				ex_cred--;
				owed++;
			end
			ex_cred += int'(ex_credit_seen);
			ex_credit_seen = ex_credit;
			if (in_credit)
				fetch_cred++;
			assert (fetch_cred <= `ID_FIFO_DEPTH)
				else abort_run("more input credits returned than were spent");
		end
	end

	// execute model, one credit back per micro-op after a random delay
	always @(posedge clk) begin
		#1;
		if (owed > 0 && hold == 0) begin
			ex_credit = 1'b1;
			owed--;
			hold = next_delay();
		end else begin
			ex_credit = 1'b0;
			if (hold > 0)
				hold--;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit)
			abort_run($sformatf("timeout after %0d cycles with %0d of %0d micro-ops issued",
				cycle_cnt, out_idx, num_rows));
	end

endmodule

`default_nettype wire
